// ==== Bender.yml ====
package:
  name: mh_cfg

sources:
  - rtl/mh_cfg_pkg.sv
  - rtl/axi_lite_cfg_slave.sv
  - rtl/miss_capture.sv
  - rtl/mh_fifo.sv
  - rtl/miss_readout.sv
  - rtl/mh_cfg_top.sv
  - target: test
    files:
      - tests/tb_clk_gen.sv
      - tests/tb_mh_cfg_top.sv

// ==== build.f ====
rtl/mh_cfg_pkg.sv
rtl/axi_lite_cfg_slave.sv
rtl/miss_capture.sv
rtl/mh_fifo.sv
rtl/miss_readout.sv
rtl/mh_cfg_top.sv
tests/tb_clk_gen.sv
tests/tb_mh_cfg_top.sv

// ==== rtl/axi_lite_cfg_slave.sv ====
`timescale 1ns/1ns
`default_nettype none

module axi_lite_cfg_slave (
  input  logic                              Clk_CI,
  input  logic                              Rst_RBI,
  input  logic [mh_cfg_pkg::ADDR_W-1:0]     s_axi_awaddr_i,
  input  logic                              s_axi_awvalid_i,
  output logic                              s_axi_awready_o,
  input  logic [mh_cfg_pkg::DATA_W-1:0]     s_axi_wdata_i,
  input  logic [mh_cfg_pkg::DATA_W/8-1:0]   s_axi_wstrb_i,
  input  logic                              s_axi_wvalid_i,
  output logic                              s_axi_wready_o,
  output logic [1:0]                        s_axi_bresp_o,
  output logic                              s_axi_bvalid_o,
  input  logic                              s_axi_bready_i,
  input  logic [mh_cfg_pkg::ADDR_W-1:0]     s_axi_araddr_i,
  input  logic                              s_axi_arvalid_i,
  output logic                              s_axi_arready_o,
  output logic [mh_cfg_pkg::DATA_W-1:0]     s_axi_rdata_o,
  output logic [1:0]                        s_axi_rresp_o,
  output logic                              s_axi_rvalid_o,
  input  logic                              s_axi_rready_i,
  output logic                              wr_en_o,
  output logic [mh_cfg_pkg::ADDR_W-1:0]     wr_addr_o,
  output logic [mh_cfg_pkg::DATA_W-1:0]     wr_data_o,
  output logic                              rd_valid_o,
  output logic                              rd_fire_o,
  output logic [mh_cfg_pkg::ADDR_W-1:0]     rd_addr_o,
  input  logic [mh_cfg_pkg::DATA_W-1:0]     rd_data_i
);

  logic [mh_cfg_pkg::ADDR_W-1:0]   aw_addr_q;
  logic [mh_cfg_pkg::ADDR_W-1:0]   ar_addr_q;
  logic [mh_cfg_pkg::DATA_W-1:0]   w_data_q;
  logic [mh_cfg_pkg::DATA_W/8-1:0] w_strb_q;

  logic awready_q;
  logic wready_q;
  logic arready_q;
  logic aw_done_q;
  logic w_done_q;
  logic aw_done_dly_q;
  logic w_done_dly_q;
  logic b_done_q;   // write response accepted
  logic ar_done_q;
  logic r_done_q;   // read response accepted
  logic pair_rise;
  logic bvalid;
  logic rvalid;

  // payload capture
  always_ff @(posedge Clk_CI)
  begin
    if (awready_q && s_axi_awvalid_i)
      aw_addr_q <= s_axi_awaddr_i;
    if (wready_q && s_axi_wvalid_i)
    begin
      w_data_q <= s_axi_wdata_i;
      w_strb_q <= s_axi_wstrb_i;
    end
    if (arready_q && s_axi_arvalid_i)
      ar_addr_q <= s_axi_araddr_i;
  end

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      awready_q     <= 1'b1;
      wready_q      <= 1'b1;
      arready_q     <= 1'b1;
      aw_done_q     <= 1'b0;
      w_done_q      <= 1'b0;
      aw_done_dly_q <= 1'b0;
      w_done_dly_q  <= 1'b0;
      b_done_q      <= 1'b0;
      ar_done_q     <= 1'b0;
      r_done_q      <= 1'b0;
    end
    else
    begin
      aw_done_dly_q <= aw_done_q;
      w_done_dly_q  <= w_done_q;

      if (awready_q && s_axi_awvalid_i)
      begin
        awready_q <= 1'b0;
        aw_done_q <= 1'b1;
      end
      else if (aw_done_q && b_done_q)
      begin
        awready_q <= 1'b1;
        aw_done_q <= 1'b0;
      end

      if (wready_q && s_axi_wvalid_i)
      begin
        wready_q <= 1'b0;
        w_done_q <= 1'b1;
      end
      else if (w_done_q && b_done_q)
      begin
        wready_q <= 1'b1;
        w_done_q <= 1'b0;
      end

      // b done sticks until both channels have released
      if (aw_done_q && w_done_q)
      begin
        if (bvalid && s_axi_bready_i)
          b_done_q <= 1'b1;
      end
      else
        b_done_q <= 1'b0;

      if (arready_q && s_axi_arvalid_i)
      begin
        arready_q <= 1'b0;
        ar_done_q <= 1'b1;
      end
      else if (ar_done_q && r_done_q)
      begin
        arready_q <= 1'b1;
        ar_done_q <= 1'b0;
      end

      if (ar_done_q)
      begin
        if (rvalid && s_axi_rready_i)
          r_done_q <= 1'b1;
      end
      else
        r_done_q <= 1'b0;
    end
  end

  // first cycle with both address and data in hand
  assign pair_rise = (w_done_q && !w_done_dly_q && aw_done_q) ||
                     (aw_done_q && !aw_done_dly_q && w_done_q);

  assign bvalid = aw_done_q && w_done_q && !b_done_q;
  assign rvalid = ar_done_q && !r_done_q;

  assign wr_en_o   = pair_rise && (|w_strb_q); // zero strobe only gets a response
  assign wr_addr_o = aw_addr_q;
  assign wr_data_o = w_data_q;

  assign rd_valid_o = rvalid;
  assign rd_fire_o  = rvalid && s_axi_rready_i;
  assign rd_addr_o  = ar_addr_q;

  assign s_axi_awready_o = awready_q;
  assign s_axi_wready_o  = wready_q;
  assign s_axi_bresp_o   = mh_cfg_pkg::resp_ok;
  assign s_axi_bvalid_o  = bvalid;
  assign s_axi_arready_o = arready_q;
  assign s_axi_rdata_o   = rd_data_i;
  assign s_axi_rresp_o   = mh_cfg_pkg::resp_ok;
  assign s_axi_rvalid_o  = rvalid;

  assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    s_axi_bvalid_o && !s_axi_bready_i |=> s_axi_bvalid_o)
    else $error("bvalid dropped before bready");

  assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    s_axi_rvalid_o && !s_axi_rready_i |=> s_axi_rvalid_o)
    else $error("rvalid dropped before rready");

endmodule

`default_nettype wire

// ==== rtl/mh_cfg_pkg.sv ====
`default_nettype none

package mh_cfg_pkg;

  // bus geometry
  localparam int unsigned DATA_W = 32;
  localparam int unsigned ADDR_W = 16;

  // miss payload widths
  localparam int unsigned VA_W   = 32;
  localparam int unsigned META_W = 10;

  localparam int unsigned CONF_W = 2; // bit 0 fifo disable, bit 1 multi-hit

  localparam logic [ADDR_W-1:0] REG_ADDR_FIFO = 16'h0000;
  localparam logic [ADDR_W-1:0] REG_META_FIFO = 16'h0008;
  localparam logic [ADDR_W-1:0] REG_CONF      = 16'h000C;

  localparam logic [1:0] resp_ok = 2'b00;

  // meta fifo word as seen on the bus
  typedef struct packed {
    logic                       empty;  // bit 31
    logic [DATA_W-META_W-2:0]   rsvd;
    logic [META_W-1:0]          meta;
  } meta_status_t;

  typedef union packed {
    logic [VA_W-1:0] addr;      // whole word is a virtual address
    meta_status_t    meta_st;
  } data_word_u;

endpackage

`default_nettype wire

// ==== rtl/mh_cfg_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module mh_cfg_top #(
  parameter int unsigned MH_FIFO_DEPTH = 4
) (
  input  logic                              Clk_CI,
  input  logic                              Rst_RBI,
  input  logic [mh_cfg_pkg::ADDR_W-1:0]     s_axi_awaddr_i,
  input  logic                              s_axi_awvalid_i,
  output logic                              s_axi_awready_o,
  input  logic [mh_cfg_pkg::DATA_W-1:0]     s_axi_wdata_i,
  input  logic [mh_cfg_pkg::DATA_W/8-1:0]   s_axi_wstrb_i,
  input  logic                              s_axi_wvalid_i,
  output logic                              s_axi_wready_o,
  output logic [1:0]                        s_axi_bresp_o,
  output logic                              s_axi_bvalid_o,
  input  logic                              s_axi_bready_i,
  input  logic [mh_cfg_pkg::ADDR_W-1:0]     s_axi_araddr_i,
  input  logic                              s_axi_arvalid_i,
  output logic                              s_axi_arready_o,
  output logic [mh_cfg_pkg::DATA_W-1:0]     s_axi_rdata_o,
  output logic [1:0]                        s_axi_rresp_o,
  output logic                              s_axi_rvalid_o,
  input  logic                              s_axi_rready_i,
  input  logic                              Miss_SI,
  input  logic [mh_cfg_pkg::VA_W-1:0]       MissAddr_DI,
  input  logic [mh_cfg_pkg::META_W-1:0]     MissMeta_DI,
  output logic                              MhFifoFull_SO,
  output logic                              L1AllowMultiHit_SO
);

  logic                          wr_en;
  logic [mh_cfg_pkg::ADDR_W-1:0] wr_addr;
  logic [mh_cfg_pkg::DATA_W-1:0] wr_data;
  logic                          rd_valid;
  logic                          rd_fire;
  logic [mh_cfg_pkg::ADDR_W-1:0] rd_addr;
  logic [mh_cfg_pkg::DATA_W-1:0] rd_data;
  logic [mh_cfg_pkg::CONF_W-1:0] conf;

  logic                          addr_push;
  logic [mh_cfg_pkg::VA_W-1:0]   addr_push_data;
  logic                          addr_pop;
  logic [mh_cfg_pkg::VA_W-1:0]   addr_head;
  logic                          addr_full;
  logic                          addr_empty;

  logic                          meta_push;
  logic [mh_cfg_pkg::META_W-1:0] meta_push_data;
  logic                          meta_pop;
  logic [mh_cfg_pkg::META_W-1:0] meta_head;
  logic                          meta_full;
  logic                          meta_empty;

  axi_lite_cfg_slave u_slave (
    .Clk_CI          (Clk_CI),
    .Rst_RBI         (Rst_RBI),
    .s_axi_awaddr_i  (s_axi_awaddr_i),
    .s_axi_awvalid_i (s_axi_awvalid_i),
    .s_axi_awready_o (s_axi_awready_o),
    .s_axi_wdata_i   (s_axi_wdata_i),
    .s_axi_wstrb_i   (s_axi_wstrb_i),
    .s_axi_wvalid_i  (s_axi_wvalid_i),
    .s_axi_wready_o  (s_axi_wready_o),
    .s_axi_bresp_o   (s_axi_bresp_o),
    .s_axi_bvalid_o  (s_axi_bvalid_o),
    .s_axi_bready_i  (s_axi_bready_i),
    .s_axi_araddr_i  (s_axi_araddr_i),
    .s_axi_arvalid_i (s_axi_arvalid_i),
    .s_axi_arready_o (s_axi_arready_o),
    .s_axi_rdata_o   (s_axi_rdata_o),
    .s_axi_rresp_o   (s_axi_rresp_o),
    .s_axi_rvalid_o  (s_axi_rvalid_o),
    .s_axi_rready_i  (s_axi_rready_i),
    .wr_en_o         (wr_en),
    .wr_addr_o       (wr_addr),
    .wr_data_o       (wr_data),
    .rd_valid_o      (rd_valid),
    .rd_fire_o       (rd_fire),
    .rd_addr_o       (rd_addr),
    .rd_data_i       (rd_data)
  );

  miss_capture u_capture (
    .Clk_CI            (Clk_CI),
    .Rst_RBI           (Rst_RBI),
    .miss_i            (Miss_SI),
    .miss_addr_i       (MissAddr_DI),
    .miss_meta_i       (MissMeta_DI),
    .wr_en_i           (wr_en),
    .wr_addr_i         (wr_addr),
    .wr_data_i         (wr_data),
    .addr_full_i       (addr_full),
    .meta_full_i       (meta_full),
    .addr_push_o       (addr_push),
    .addr_push_data_o  (addr_push_data),
    .meta_push_o       (meta_push),
    .meta_push_data_o  (meta_push_data),
    .conf_o            (conf),
    .fifo_full_o       (MhFifoFull_SO),
    .allow_multi_hit_o (L1AllowMultiHit_SO)
  );

  // faulting virtual address
  mh_fifo #(
    .MH_FIFO_DEPTH (MH_FIFO_DEPTH),
    .MH_FIFO_WIDTH (mh_cfg_pkg::VA_W)
  ) u_addr_fifo (
    .Clk_CI      (Clk_CI),
    .Rst_RBI     (Rst_RBI),
    .push_i      (addr_push),
    .push_data_i (addr_push_data),
    .pop_i       (addr_pop),
    .head_o      (addr_head),
    .full_o      (addr_full),
    .empty_o     (addr_empty)
  );

  mh_fifo #(
    .MH_FIFO_DEPTH (MH_FIFO_DEPTH),
    .MH_FIFO_WIDTH (mh_cfg_pkg::META_W)
  ) u_meta_fifo (
    .Clk_CI      (Clk_CI),
    .Rst_RBI     (Rst_RBI),
    .push_i      (meta_push),
    .push_data_i (meta_push_data),
    .pop_i       (meta_pop),
    .head_o      (meta_head),
    .full_o      (meta_full),
    .empty_o     (meta_empty)
  );

  miss_readout u_readout (
    .rd_valid_i   (rd_valid),
    .rd_fire_i    (rd_fire),
    .rd_addr_i    (rd_addr),
    .addr_head_i  (addr_head),
    .addr_empty_i (addr_empty),
    .meta_head_i  (meta_head),
    .meta_empty_i (meta_empty),
    .conf_i       (conf),
    .addr_pop_o   (addr_pop),
    .meta_pop_o   (meta_pop),
    .rd_data_o    (rd_data)
  );

endmodule

`default_nettype wire

// ==== rtl/mh_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

module mh_fifo #(
  parameter int unsigned MH_FIFO_DEPTH = 4,
  parameter int unsigned MH_FIFO_WIDTH = 32
) (
  input  logic                     Clk_CI,
  input  logic                     Rst_RBI,
  input  logic                     push_i,
  input  logic [MH_FIFO_WIDTH-1:0] push_data_i,
  input  logic                     pop_i,
  output logic [MH_FIFO_WIDTH-1:0] head_o,
  output logic                     full_o,
  output logic                     empty_o
);

  localparam int unsigned PTR_W = (MH_FIFO_DEPTH > 1) ? $clog2(MH_FIFO_DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(MH_FIFO_DEPTH + 1);

  logic [MH_FIFO_WIDTH-1:0] mem_q [MH_FIFO_DEPTH];
  logic [PTR_W-1:0]         wr_ptr_q;
  logic [PTR_W-1:0]         rd_ptr_q;
  logic [CNT_W-1:0]         count_q;
  logic                     do_push;
  logic                     do_pop;

  assign full_o  = (count_q == CNT_W'(MH_FIFO_DEPTH));
  assign empty_o = (count_q == '0);
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;
  assign head_o  = mem_q[rd_ptr_q];

  always_ff @(posedge Clk_CI)
  begin
    if (do_push)
      mem_q[wr_ptr_q] <= push_data_i;
  end

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (do_push)  // wrap also for non power of two depths
        wr_ptr_q <= (wr_ptr_q == PTR_W'(MH_FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (do_pop)
        rd_ptr_q <= (rd_ptr_q == PTR_W'(MH_FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      if (do_push && !do_pop)
        count_q <= count_q + 1'b1;
      else if (do_pop && !do_push)
        count_q <= count_q - 1'b1;
    end
  end

  assert property (@(posedge Clk_CI) disable iff (!Rst_RBI) pop_i |-> !empty_o)
    else $error("pop on empty fifo");

endmodule

`default_nettype wire

// ==== rtl/miss_capture.sv ====
`timescale 1ns/1ns
`default_nettype none

module miss_capture (
  input  logic                              Clk_CI,
  input  logic                              Rst_RBI,
  input  logic                              miss_i,
  input  logic [mh_cfg_pkg::VA_W-1:0]       miss_addr_i,
  input  logic [mh_cfg_pkg::META_W-1:0]     miss_meta_i,
  input  logic                              wr_en_i,
  input  logic [mh_cfg_pkg::ADDR_W-1:0]     wr_addr_i,
  input  logic [mh_cfg_pkg::DATA_W-1:0]     wr_data_i,
  input  logic                              addr_full_i,
  input  logic                              meta_full_i,
  output logic                              addr_push_o,
  output logic [mh_cfg_pkg::VA_W-1:0]       addr_push_data_o,
  output logic                              meta_push_o,
  output logic [mh_cfg_pkg::META_W-1:0]     meta_push_data_o,
  output logic [mh_cfg_pkg::CONF_W-1:0]     conf_o,
  output logic                              fifo_full_o,
  output logic                              allow_multi_hit_o
);

  mh_cfg_pkg::data_word_u wr_word;

  logic [mh_cfg_pkg::CONF_W-1:0] conf_q;
  logic fifos_off;
  logic sw_addr_wr;
  logic sw_meta_wr;
  logic sw_conf_wr;

  assign wr_word   = wr_data_i;
  assign fifos_off = conf_q[0];

  assign sw_addr_wr = wr_en_i && (wr_addr_i == mh_cfg_pkg::REG_ADDR_FIFO);
  assign sw_meta_wr = wr_en_i && (wr_addr_i == mh_cfg_pkg::REG_META_FIFO);
  assign sw_conf_wr = wr_en_i && (wr_addr_i == mh_cfg_pkg::REG_CONF);

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
      conf_q <= '0;
    else if (sw_conf_wr)
      conf_q <= wr_word.addr[mh_cfg_pkg::CONF_W-1:0];
  end

  // miss wins over a software push in the same cycle
  assign addr_push_o      = !fifos_off && (miss_i || sw_addr_wr);
  assign addr_push_data_o = miss_i ? miss_addr_i : wr_word.addr;
  assign meta_push_o      = !fifos_off && (miss_i || sw_meta_wr);
  assign meta_push_data_o = miss_i ? miss_meta_i : wr_word.meta_st.meta;

  // the fifo drops it, we only report
  assign fifo_full_o = (addr_push_o && addr_full_i) || (meta_push_o && meta_full_i);

  assign conf_o            = conf_q;
  assign allow_multi_hit_o = conf_q[1];

endmodule

`default_nettype wire

// ==== rtl/miss_readout.sv ====
`timescale 1ns/1ns
`default_nettype none

module miss_readout (
  input  logic                              rd_valid_i,
  input  logic                              rd_fire_i,
  input  logic [mh_cfg_pkg::ADDR_W-1:0]     rd_addr_i,
  input  logic [mh_cfg_pkg::VA_W-1:0]       addr_head_i,
  input  logic                              addr_empty_i,
  input  logic [mh_cfg_pkg::META_W-1:0]     meta_head_i,
  input  logic                              meta_empty_i,
  input  logic [mh_cfg_pkg::CONF_W-1:0]     conf_i,
  output logic                              addr_pop_o,
  output logic                              meta_pop_o,
  output logic [mh_cfg_pkg::DATA_W-1:0]     rd_data_o
);

  mh_cfg_pkg::data_word_u rd_word;

  always_comb
  begin
    rd_word    = '0;  // unmapped offsets read zero
    addr_pop_o = 1'b0;
    meta_pop_o = 1'b0;
    if (rd_valid_i)
    begin
      case (rd_addr_i)
        mh_cfg_pkg::REG_ADDR_FIFO:
        begin
          rd_word.addr = addr_head_i;
          addr_pop_o   = rd_fire_i && !addr_empty_i; // once, on the handshake
        end
        mh_cfg_pkg::REG_META_FIFO:
        begin
          rd_word.meta_st.empty = meta_empty_i;
          rd_word.meta_st.meta  = meta_head_i;
          meta_pop_o            = rd_fire_i && !meta_empty_i;
        end
        mh_cfg_pkg::REG_CONF:
          rd_word.addr[mh_cfg_pkg::CONF_W-1:0] = conf_i;
        default:
          rd_word = '0;
      endcase
    end
  end

  assign rd_data_o = rd_word;

endmodule

`default_nettype wire

// ==== tests/tb_clk_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen #(
  parameter int unsigned PERIOD_NS  = 4,
  parameter int unsigned RST_CYCLES = 10
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial
  begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  initial
  begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    #1 rst_n_o = 1'b1;  // release off the edge
  end

endmodule

`default_nettype wire

// ==== tests/tb_mh_cfg_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_mh_cfg_top;

  localparam int unsigned ADDR_W = mh_cfg_pkg::ADDR_W;
  localparam int unsigned DATA_W = mh_cfg_pkg::DATA_W;
  localparam int unsigned VA_W   = mh_cfg_pkg::VA_W;
  localparam int unsigned META_W = mh_cfg_pkg::META_W;

  localparam logic [DATA_W-1:0] ALL_BITS   = 32'hFFFF_FFFF;
  localparam logic [DATA_W-1:0] EMPTY_MASK = 32'hFFFF_FC00; // flag and reserved bits only

  typedef enum logic [1:0] {
    OP_MISS,
    OP_WRITE,
    OP_READ
  } op_e;

  typedef struct packed {
    op_e               kind;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;  // miss va, write data or expected read data
    logic [DATA_W-1:0] mask;
    logic [META_W-1:0] meta;
    logic              flag;  // full during a miss, multi-hit after a write
  } entry_t;

  logic                Clk_CI;
  logic                Rst_RBI;
  logic [ADDR_W-1:0]   aw_addr;
  logic                aw_valid;
  logic                aw_ready;
  logic [DATA_W-1:0]   w_data;
  logic [DATA_W/8-1:0] w_strb;
  logic                w_valid;
  logic                w_ready;
  logic [1:0]          b_resp;
  logic                b_valid;
  logic                b_ready;
  logic [ADDR_W-1:0]   ar_addr;
  logic                ar_valid;
  logic                ar_ready;
  logic [DATA_W-1:0]   r_data;
  logic [1:0]          r_resp;
  logic                r_valid;
  logic                r_ready;
  logic                miss;
  logic [VA_W-1:0]     miss_addr;
  logic [META_W-1:0]   miss_meta;
  logic                fifo_full;
  logic                multi_hit;

  entry_t      stim_q[$];
  logic [31:0] lfsr_q      = 32'h5a73;
  int unsigned cycle_cnt   = 0;
  int unsigned cycle_limit = 0;

  tb_clk_gen #(
    .PERIOD_NS  (4),
    .RST_CYCLES (10)
  ) u_clk_gen (
    .clk_o   (Clk_CI),
    .rst_n_o (Rst_RBI)
  );

  mh_cfg_top #(
    .MH_FIFO_DEPTH (4)
  ) dut (
    .Clk_CI             (Clk_CI),
    .Rst_RBI            (Rst_RBI),
    .s_axi_awaddr_i     (aw_addr),
    .s_axi_awvalid_i    (aw_valid),
    .s_axi_awready_o    (aw_ready),
    .s_axi_wdata_i      (w_data),
    .s_axi_wstrb_i      (w_strb),
    .s_axi_wvalid_i     (w_valid),
    .s_axi_wready_o     (w_ready),
    .s_axi_bresp_o      (b_resp),
    .s_axi_bvalid_o     (b_valid),
    .s_axi_bready_i     (b_ready),
    .s_axi_araddr_i     (ar_addr),
    .s_axi_arvalid_i    (ar_valid),
    .s_axi_arready_o    (ar_ready),
    .s_axi_rdata_o      (r_data),
    .s_axi_rresp_o      (r_resp),
    .s_axi_rvalid_o     (r_valid),
    .s_axi_rready_i     (r_ready),
    .Miss_SI            (miss),
    .MissAddr_DI        (miss_addr),
    .MissMeta_DI        (miss_meta),
    .MhFifoFull_SO      (fifo_full),
    .L1AllowMultiHit_SO (multi_hit)
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_word(input mh_cfg_pkg::data_word_u got,
                            input mh_cfg_pkg::data_word_u exp,
                            input logic [DATA_W-1:0] mask, input string msg);
    if ((got.addr & mask) !== (exp.addr & mask))
      abort_run($sformatf("CHECK FAILED at %0t ns: %s read %h, expected %h (mask %h)",
                          $time, msg, got.addr, exp.addr, mask));
  endtask

  task automatic check_flag(input logic got, input logic exp, input string msg);
    if (got !== exp)
      abort_run($sformatf("CHECK FAILED at %0t ns: %s is %b, expected %b",
                          $time, msg, got, exp));
  endtask

  // galois form, taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  task automatic rand_delay(output int unsigned n);
    n = 0;
    repeat (2)
    begin
      n      = (n << 1) | lfsr_q[0];
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  task automatic next_cycle();
    @(posedge Clk_CI);
    #1;
  endtask

  function automatic logic [DATA_W-1:0] meta_word(input logic empty, input logic [META_W-1:0] m);
    return {empty, {(DATA_W-META_W-1){1'b0}}, m};
  endfunction

  task automatic bus_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    logic        aw_go;
    logic        w_go;
    logic        b_go;
    int unsigned dly;
    aw_addr  = addr;
    aw_valid = 1'b1;
    w_data   = data;
    w_strb   = '1;
    w_valid  = 1'b1;
    while (aw_valid || w_valid)
    begin
      @(negedge Clk_CI);
      aw_go = aw_valid && aw_ready;
      w_go  = w_valid && w_ready;
      next_cycle();
      if (aw_go)
        aw_valid = 1'b0;
      if (w_go)
        w_valid = 1'b0;
    end
    rand_delay(dly);
    repeat (dly)
      next_cycle();
    b_ready = 1'b1;
    do
    begin
      @(negedge Clk_CI);
      b_go = b_valid;
      if (b_go)
        check_flag(b_resp == 2'b00, 1'b1, "bresp OKAY");
      next_cycle();
    end
    while (!b_go);
    b_ready = 1'b0;
  endtask

  task automatic bus_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
    logic        go;
    int unsigned dly;
    ar_addr  = addr;
    ar_valid = 1'b1;
    do
    begin
      @(negedge Clk_CI);
      go = ar_ready;
      next_cycle();
    end
    while (!go);
    ar_valid = 1'b0;
    rand_delay(dly);  // rvalid has to hold meanwhile
    repeat (dly)
      next_cycle();
    r_ready = 1'b1;
    do
    begin
      @(negedge Clk_CI);
      go   = r_valid;
      data = r_data;
      if (go)
        check_flag(r_resp == 2'b00, 1'b1, "rresp OKAY");
      next_cycle();
    end
    while (!go);
    r_ready = 1'b0;
  endtask

  task automatic send_miss(input logic [VA_W-1:0] va, input logic [META_W-1:0] m,
                           input logic exp_full);
    miss      = 1'b1;
    miss_addr = va;
    miss_meta = m;
    @(negedge Clk_CI);
    check_flag(fifo_full, exp_full, "fifo full during miss");
    next_cycle();
    miss      = 1'b0;
    miss_addr = '0;
    miss_meta = '0;
  endtask

  task automatic add_miss(input logic [VA_W-1:0] va, input logic [META_W-1:0] m,
                          input logic exp_full);
    entry_t e;
    e      = '0;
    e.kind = OP_MISS;
    e.data = va;
    e.meta = m;
    e.flag = exp_full;
    stim_q.push_back(e);
  endtask

  task automatic add_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                           input logic exp_mh);
    entry_t e;
    e      = '0;
    e.kind = OP_WRITE;
    e.addr = addr;
    e.data = data;
    e.flag = exp_mh;
    stim_q.push_back(e);
  endtask

  task automatic add_read(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] exp,
                          input logic [DATA_W-1:0] mask);
    entry_t e;
    e      = '0;
    e.kind = OP_READ;
    e.addr = addr;
    e.data = exp;
    e.mask = mask;
    stim_q.push_back(e);
  endtask

  task automatic build_table();
    int i;
    // arrival order through both fifos
    add_miss(32'h1000_0001, 10'h011, 1'b0);
    add_miss(32'h2000_0002, 10'h022, 1'b0);
    add_miss(32'h3000_0003, 10'h033, 1'b0);
    add_read(mh_cfg_pkg::REG_ADDR_FIFO, 32'h1000_0001, ALL_BITS);
    add_read(mh_cfg_pkg::REG_ADDR_FIFO, 32'h2000_0002, ALL_BITS);
    add_read(mh_cfg_pkg::REG_ADDR_FIFO, 32'h3000_0003, ALL_BITS);
    add_read(mh_cfg_pkg::REG_META_FIFO, meta_word(1'b0, 10'h011), ALL_BITS);
    add_read(mh_cfg_pkg::REG_META_FIFO, meta_word(1'b0, 10'h022), ALL_BITS);
    add_read(mh_cfg_pkg::REG_META_FIFO, meta_word(1'b0, 10'h033), ALL_BITS);
    add_read(mh_cfg_pkg::REG_META_FIFO, meta_word(1'b1, 10'h000), EMPTY_MASK);
    // multi-hit on, then fifos off
    add_write(mh_cfg_pkg::REG_CONF, 32'h2, 1'b1);
    add_read(mh_cfg_pkg::REG_CONF, 32'h2, ALL_BITS);
    add_write(mh_cfg_pkg::REG_CONF, 32'h3, 1'b1);
    add_miss(32'h4000_0004, 10'h044, 1'b0);
    add_read(mh_cfg_pkg::REG_META_FIFO, meta_word(1'b1, 10'h000), EMPTY_MASK);
    add_write(mh_cfg_pkg::REG_CONF, 32'h0, 1'b0);
    // software pushes, upper bits of the meta word dropped
    add_write(mh_cfg_pkg::REG_ADDR_FIFO, 32'hCAFE_0123, 1'b0);
    add_write(mh_cfg_pkg::REG_META_FIFO, 32'hFFFF_F2A5, 1'b0);
    add_read(mh_cfg_pkg::REG_ADDR_FIFO, 32'hCAFE_0123, ALL_BITS);
    add_read(mh_cfg_pkg::REG_META_FIFO, meta_word(1'b0, 10'h2A5), ALL_BITS);
    // fifth miss hits a full fifo
    for (i = 0; i < 5; i++)
      add_miss(32'h5000_0000 + i, 10'h050 + i, i == 4);
    for (i = 0; i < 4; i++)
      add_read(mh_cfg_pkg::REG_ADDR_FIFO, 32'h5000_0000 + i, ALL_BITS);
    for (i = 0; i < 4; i++)
      add_read(mh_cfg_pkg::REG_META_FIFO, meta_word(1'b0, 10'h050 + i), ALL_BITS);
    // unmapped reads must not pop
    add_miss(32'h6000_0006, 10'h066, 1'b0);
    add_miss(32'h7000_0007, 10'h077, 1'b0);
    add_read(16'h0004, 32'h0, ALL_BITS);
    add_read(mh_cfg_pkg::REG_ADDR_FIFO, 32'h6000_0006, ALL_BITS);
    add_read(16'h0010, 32'h0, ALL_BITS);
    add_read(mh_cfg_pkg::REG_ADDR_FIFO, 32'h7000_0007, ALL_BITS);
    add_read(mh_cfg_pkg::REG_META_FIFO, meta_word(1'b0, 10'h066), ALL_BITS);
    add_read(mh_cfg_pkg::REG_META_FIFO, meta_word(1'b0, 10'h077), ALL_BITS);
    add_read(mh_cfg_pkg::REG_META_FIFO, meta_word(1'b1, 10'h000), EMPTY_MASK);
  endtask

  always @(posedge Clk_CI)
  begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit)
      abort_run($sformatf("timeout: test table did not finish within %0d cycles",
                          cycle_limit));
  end

  initial
  begin
    logic [DATA_W-1:0] rd;
    entry_t            e;
    aw_addr   = '0;
    aw_valid  = 1'b0;
    w_data    = '0;
    w_strb    = '0;
    w_valid   = 1'b0;
    b_ready   = 1'b0;
    ar_addr   = '0;
    ar_valid  = 1'b0;
    r_ready   = 1'b0;
    miss      = 1'b0;
    miss_addr = '0;
    miss_meta = '0;
    build_table();
    cycle_limit = 10 + 40 * stim_q.size();

    wait (Rst_RBI === 1'b1);
    @(negedge Clk_CI);
    check_flag(aw_ready, 1'b1, "awready after reset");
    check_flag(w_ready, 1'b1, "wready after reset");
    check_flag(ar_ready, 1'b1, "arready after reset");
    check_flag(b_valid, 1'b0, "bvalid after reset");
    check_flag(r_valid, 1'b0, "rvalid after reset");
    check_flag(fifo_full, 1'b0, "fifo full after reset");
    check_flag(multi_hit, 1'b0, "multi-hit after reset");
    next_cycle();

    foreach (stim_q[i])
    begin
      e = stim_q[i];
      case (e.kind)
        OP_MISS:
          send_miss(e.data, e.meta, e.flag);
        OP_WRITE:
        begin
          bus_write(e.addr, e.data);
          check_flag(multi_hit, e.flag, "multi-hit after write");
        end
        default:
        begin
          bus_read(e.addr, rd);
          check_word(rd, e.data, e.mask, $sformatf("entry %0d offset %h", i, e.addr));
        end
      endcase
    end

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire
